/* hw/rv_pkg.sv */
package rv_pkg;

  // machine word width for RV32
  localparam int XLEN = 32;

  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // branch funct3 handed to the pc unit unchanged
  typedef logic [2:0] branch_cond_t;

  // major opcodes, base integer subset only
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_LUI     = 7'b01_101_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_JAL     = 7'b11_011_11;
  localparam opcode_t OP_JALR    = 7'b11_001_11;
  localparam opcode_t OP_ENVIRON = 7'b11_100_11;

  // funct3 for the ALU groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7, alternate form selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  // pc step between sequential instructions
  localparam word_t INSN_BYTES = 32'd4;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // forwards operand b, used by lui
    ALU_PASS_B
  } alu_op_t;

endpackage

/* hw/rv_decoder.sv */
module rv_decoder (
  input  rv_pkg::word_t        insn,
  output rv_pkg::reg_idx_t     rs1,
  output rv_pkg::reg_idx_t     rs2,
  output rv_pkg::reg_idx_t     wb_rd,
  output rv_pkg::word_t        imm,
  output rv_pkg::alu_op_t      alu_op,
  output logic                 alu_use_imm,
  output logic                 is_branch,
  output logic                 is_jal,
  output logic                 is_jalr,
  output rv_pkg::branch_cond_t branch_cond,
  output logic                 wb_src_link,
  output logic                 wb_en,
  output logic                 halt
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  word_t      imm_shamt;
  logic       writes;

  // instruction fields
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign wb_rd  = insn[11:7];

  // immediates, all sign extended except shamt and U
  assign imm_i     = {{20{insn[31]}}, insn[31:20]};
  assign imm_b     = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j     = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u     = {insn[31:12], 12'b0};
  assign imm_shamt = {27'b0, insn[24:20]};

  assign branch_cond = funct3;

  always_comb begin
    alu_op      = ALU_ADD;
    alu_use_imm = 1'b0;
    imm         = imm_i;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    wb_src_link = 1'b0;
    writes      = 1'b0;
    halt        = 1'b0;

    case (opcode)
      OP_REG_IMM: begin
        alu_use_imm = 1'b1;
        writes      = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          F3_SLL: begin
            alu_op = ALU_SLL;
            imm    = imm_shamt;
            writes = (funct7 == F7_BASE);
          end
          F3_SRL_SRA: begin
            alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            imm    = imm_shamt;
            writes = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      OP_REG_REG: begin
        // only sub and sra have a legal alternate form
        writes = (funct7 == F7_BASE) ||
                 ((funct7 == F7_ALT) && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
        case (funct3)
          F3_ADD_SUB: alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
        endcase
      end
      OP_LUI: begin
        alu_op      = ALU_PASS_B;
        alu_use_imm = 1'b1;
        imm         = imm_u;
        writes      = 1'b1;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        // funct3 010 and 011 are not branches
        is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      OP_JAL: begin
        imm         = imm_j;
        is_jal      = 1'b1;
        wb_src_link = 1'b1;
        writes      = 1'b1;
      end
      OP_JALR: begin
        is_jalr     = (funct3 == 3'b000);
        wb_src_link = 1'b1;
        writes      = (funct3 == 3'b000);
      end
      OP_ENVIRON: begin
        // ecall only, everything above the opcode is zero
        halt = (insn[31:7] == 25'd0);
      end
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  // x0 is never written
  assign wb_en = writes && (wb_rd != 5'd0);

endmodule

/* hw/rv_alu.sv */
module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits of b
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SLT: begin
        result = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SRL: begin
        result = a >> shamt;
      end
      ALU_SRA: begin
        // arithmetic, sign bit fills from the left
        result = $signed(a) >>> shamt;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_PASS_B: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* hw/rv_regfile.sv */
module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  // combinational reads, x0 always zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* hw/rv_pc_unit.sv */
module rv_pc_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 is_branch,
  input  logic                 is_jal,
  input  logic                 is_jalr,
  input  rv_pkg::branch_cond_t branch_cond,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  input  rv_pkg::word_t        imm,
  output rv_pkg::word_t        pc,
  output rv_pkg::word_t        link
);
  import rv_pkg::*;

  logic  taken;
  word_t pc_next;
  word_t jalr_sum;

  always_comb begin
    case (branch_cond)
      F3_BEQ:  taken = rs1_data == rs2_data;
      F3_BNE:  taken = rs1_data != rs2_data;
      F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      // unsigned forms compare raw bit patterns
      F3_BLTU: taken = rs1_data < rs2_data;
      F3_BGEU: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign link     = pc + INSN_BYTES;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if (is_jalr) begin
      // target low bit is dropped
      pc_next = {jalr_sum[XLEN-1:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = link;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* hw/rv_core.sv */
module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  output rv_pkg::word_t    pc,
  output logic             halt,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);
  import rv_pkg::*;

  reg_idx_t     rs1;
  reg_idx_t     rs2;
  word_t        imm;
  alu_op_t      alu_op;
  logic         alu_use_imm;
  logic         is_branch;
  logic         is_jal;
  logic         is_jalr;
  branch_cond_t branch_cond;
  logic         wb_src_link;
  word_t        rs1_data;
  word_t        rs2_data;
  word_t        alu_b;
  word_t        alu_result;
  word_t        link;

  rv_decoder i_decoder (
    .insn        (insn),
    .rs1         (rs1),
    .rs2         (rs2),
    .wb_rd       (wb_rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_use_imm (alu_use_imm),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .branch_cond (branch_cond),
    .wb_src_link (wb_src_link),
    .wb_en       (wb_en),
    .halt        (halt)
  );

  // register file written with the same data seen on the trace
  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_en),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = alu_use_imm ? imm : rs2_data;

  rv_alu i_alu (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit i_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .branch_cond (branch_cond),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .link        (link)
  );

  // jumps write the return address
  assign wb_data = wb_src_link ? link : alu_result;

endmodule

/* testbench/rv_core_asserts.sv */
module rv_core_asserts (
  input logic             clk,
  input logic             rst,
  input rv_pkg::word_t    pc,
  input logic             halt,
  input logic             wb_en,
  input rv_pkg::reg_idx_t wb_rd
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions for the testbench summary
  int failures = 0;

  // fetch always on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      failures++;
      $error("pc %h is not word aligned", pc);
    end

  // x0 never shows up as a write target
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_rd != 5'd0)
    else begin
      failures++;
      $error("write-back enabled with rd x0");
    end

  halt_without_wb: assert property (@(posedge clk) disable iff (rst) !(halt && wb_en))
    else begin
      failures++;
      $error("halt and write-back high in the same cycle");
    end

  // first fetch after reset is at address 0
  pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
    else begin
      failures++;
      $error("pc %h after reset, expected 0", pc);
    end

endmodule

bind rv_core rv_core_asserts i_asserts (
  .clk   (clk),
  .rst   (rst),
  .pc    (pc),
  .halt  (halt),
  .wb_en (wb_en),
  .wb_rd (wb_rd)
);

/* testbench/rv_core_tb.sv */
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int RUN_CYCLES   = 3000;

  logic     clk;
  logic     rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // program memory indexed by pc[9:2] so targets wrap
  word_t imem [256];
  word_t ref_regs [NUM_REGS];
  word_t ref_pc;
  word_t rng;
  int    pc_errors;
  int    wb_errors;
  int    halt_errors;

  rv_core i_dut (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog with some slack past reset and the full run
  initial begin
    #((RESET_CYCLES + RUN_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display("TEST FAILED");
    $finish;
  end

  function automatic word_t xorshift();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // expected write-back and next pc of one instruction from the model state
  task automatic model_step(input word_t w, output logic en, output word_t data,
                            output word_t npc);
    word_t      a;
    word_t      b;
    word_t      op_b;
    word_t      imm_i;
    word_t      sra_val;
    logic [2:0] f3;
    logic       reg_form;
    logic       alt;
    logic       taken;
    a        = ref_regs[w[19:15]];
    b        = ref_regs[w[24:20]];
    imm_i    = {{20{w[31]}}, w[31:20]};
    f3       = w[14:12];
    reg_form = w[6:0] == OP_REG_REG;
    op_b     = reg_form ? b : imm_i;
    sra_val  = $signed(a) >>> op_b[4:0];
    // alternate funct7 selects sra and register-form sub
    alt      = w[31:25] == F7_ALT && (f3 == F3_SRL_SRA || (reg_form && f3 == F3_ADD_SUB));
    taken    = 1'b0;
    en       = 1'b0;
    data     = ref_pc + INSN_BYTES;
    npc      = ref_pc + INSN_BYTES;
    case (w[6:0])
      OP_REG_IMM, OP_REG_REG: begin
        en = alt || w[31:25] == F7_BASE || (!reg_form && f3 != F3_SLL && f3 != F3_SRL_SRA);
        case (f3)
          F3_ADD_SUB: data = alt ? a - op_b : a + op_b;
          F3_SLL:     data = a << op_b[4:0];
          F3_SLT:     data = {31'd0, $signed(a) < $signed(op_b)};
          F3_SLTU:    data = {31'd0, a < op_b};
          F3_XOR:     data = a ^ op_b;
          F3_SRL_SRA: data = alt ? sra_val : a >> op_b[4:0];
          F3_OR:      data = a | op_b;
          default:    data = a & op_b;
        endcase
      end
      OP_LUI: begin
        en   = 1'b1;
        data = {w[31:12], 12'd0};
      end
      OP_BRANCH: begin
        case (f3)
          F3_BEQ:  taken = a == b;
          F3_BNE:  taken = a != b;
          F3_BLT:  taken = $signed(a) < $signed(b);
          F3_BGE:  taken = $signed(a) >= $signed(b);
          F3_BLTU: taken = a < b;
          F3_BGEU: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) begin
          npc = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      OP_JAL: begin
        en  = 1'b1;
        npc = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OP_JALR: begin
        en = f3 == 3'b000;
        if (en) begin
          npc = (a + imm_i) & ~32'd1;
        end
      end
      default: en = 1'b0;
    endcase
    en = en && w[11:7] != 5'd0;
  endtask

  task automatic check_pc(input word_t got, input word_t exp);
    if (got !== exp) begin
      pc_errors++;
      $display("[FAIL] %0d ns: pc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_wb(input logic got_en, input reg_idx_t got_rd, input word_t got_data,
                          input logic exp_en, input reg_idx_t exp_rd, input word_t exp_data);
    // rd and data only matter when a write happens
    if (got_en !== exp_en || (exp_en && (got_rd !== exp_rd || got_data !== exp_data))) begin
      wb_errors++;
      $display("[FAIL] %0d ns: write-back en %b x%0d %h, expected en %b x%0d %h",
               $time, got_en, got_rd, got_data, exp_en, exp_rd, exp_data);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      halt_errors++;
      $display("[FAIL] %0d ns: halt %b, expected %b", $time, got, exp);
    end
  endtask

  // random program with a few ecalls and words outside the subset
  task automatic build_program();
    word_t      r;
    word_t      step;
    int         kind;
    int         i;
    reg_idx_t   rd;
    logic [2:0] f3;
    logic [6:0] f7;
    i = 0;
    while (i < 256) begin
      r    = xorshift();
      kind = int'(xorshift() & 32'd31);
      // x31 is kept as the jalr base
      rd   = r[4:0] % 5'd31;
      f3   = r[17:15];
      // forward offsets of 1 to 16 words so there are no tight loops
      step = {26'd0, r[21:18], 2'b00} + 32'd4;
      f7   = (r[22] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_BASE;
      if (kind == 0) begin
        imem[i] = {25'd0, OP_ENVIRON};
      end else if (kind < 10) begin
        imem[i] = {f7, r[24:20], r[9:5], f3, rd, OP_REG_REG};
      end else if (kind < 17) begin
        imem[i] = {(f3 == F3_SLL || f3 == F3_SRL_SRA) ? f7 : r[31:25], r[24:20], r[9:5], f3,
                   rd, OP_REG_IMM};
      end else if (kind < 19) begin
        imem[i] = {r[31:12], rd, OP_LUI};
      end else if (kind < 24) begin
        // funct3 drawn from the six branch codes
        imem[i] = {step[12], step[10:5], r[24:20], r[9:5], r[17], r[17] & r[16], r[15],
                   step[4:1], step[11], OP_BRANCH};
      end else if (kind < 26) begin
        imem[i] = {step[20], step[10:1], step[11], step[19:12], rd, OP_JAL};
      end else if (kind < 28 && i < 255) begin
        // addi from x0 sets the base while the jalr offset may carry a low bit
        imem[i] = {2'b00, r[29:22], 2'b00, 5'd0, F3_ADD_SUB, 5'd31, OP_REG_IMM};
        i++;
        imem[i] = {8'd0, r[31:30], 1'b0, r[14], 5'd31, 3'b000, rd, OP_JALR};
      end else if (kind < 30) begin
        case (r[23:22])
          2'd0:    imem[i] = {7'b000_0001, r[24:20], r[9:5], f3, rd, OP_REG_REG};
          2'd1:    imem[i] = {r[31:20], r[9:5], f3, rd, 7'b000_0011};
          2'd2:    imem[i] = {F7_ALT, r[24:20], r[9:5], F3_SLL, rd, OP_REG_IMM};
          default: imem[i] = {r[31:20], r[9:5], 3'b010, rd, OP_BRANCH};
        endcase
      end else begin
        imem[i] = {r[31:20], 5'd0, F3_ADD_SUB, rd, OP_REG_IMM};
      end
      i++;
    end
  endtask

  initial begin
    word_t w;
    logic  exp_en;
    word_t exp_data;
    word_t exp_npc;
    rst         = 1'b1;
    insn        = '0;
    rng         = 32'hc31d681c;
    pc_errors   = 0;
    wb_errors   = 0;
    halt_errors = 0;
    ref_pc      = '0;
    foreach (ref_regs[k]) begin
      ref_regs[k] = '0;
    end
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    rst  <= 1'b0;
    insn <= imem[0];
    for (int c = 0; c < RUN_CYCLES; c++) begin
      // outputs are settled by the falling edge
      @(negedge clk);
      w = imem[ref_pc[9:2]];
      model_step(w, exp_en, exp_data, exp_npc);
      check_pc(pc, ref_pc);
      check_halt(halt, w == {25'd0, OP_ENVIRON});
      check_wb(wb_en, wb_rd, wb_data, exp_en, w[11:7], exp_data);
      @(posedge clk);
      if (exp_en) begin
        ref_regs[w[11:7]] = exp_data;
      end
      ref_pc = exp_npc;
      insn <= imem[ref_pc[9:2]];
    end
    // let assertions on the last edge finish
    @(negedge clk);
    $display("errors: pc %0d, write-back %0d, halt %0d, assertions %0d",
             pc_errors, wb_errors, halt_errors, i_dut.i_asserts.failures);
    if (pc_errors + wb_errors + halt_errors + i_dut.i_asserts.failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* rv_core.f */
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_pc_unit.sv
hw/rv_core.sv
testbench/rv_core_asserts.sv
testbench/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rv_core_tb \
  -f rv_core.f \
  -o rv_core_sim

# the simulator status is not trusted alone, the log decides
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
